//--- wb_soc.f
source/wb_soc_pkg.sv
source/wb_bus_if.sv
source/wb_pri_arbiter.sv
source/wb_bus_decoder.sv
source/wb_status_regs.sv
source/wb_block_ram.sv
source/wb_sevenseg.sv
source/wb_soc.sv
verification/wb_soc_checker.sv
verification/wb_soc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the wb_soc testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module wb_soc_tb -Mdir "$BUILD_DIR" -f wb_soc.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vwb_soc_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
exit 1

//--- verification/wb_soc_tb.sv
`default_nettype none

module wb_soc_tb;

    localparam int         MAX_ENTRIES = 32;
    localparam logic [1:0] K_NONE  = 2'd0;
    localparam logic [1:0] K_EXACT = 2'd1;
    localparam logic [1:0] K_CAPT  = 2'd2;
    localparam logic [1:0] K_MORE  = 2'd3;
    localparam logic       CPU = 1'b0;
    localparam logic       DBG = 1'b1;
    localparam logic [29:0] RAM_ADDRS [4] = '{30'h004, 30'h013, 30'h100, 30'h3FF};

    logic        clk;
    logic        rst;
    logic        cpu_cyc, cpu_stb, cpu_we;
    logic [29:0] cpu_addr;
    logic [31:0] cpu_data;
    logic [3:0]  cpu_sel;
    logic        cpu_ack, cpu_stall, cpu_err;
    logic [31:0] cpu_rdata;
    logic        dbg_cyc, dbg_stb, dbg_we;
    logic [29:0] dbg_addr;
    logic [31:0] dbg_data;
    logic [3:0]  dbg_sel;
    logic        dbg_ack, dbg_stall, dbg_err;
    logic [31:0] dbg_rdata;
    logic [55:0] ssegs;
    logic        irq;

    // expectations handed to the checker
    logic [1:0]  cpu_kind, dbg_kind;
    logic [31:0] cpu_exp, dbg_exp;
    logic        cpu_exp_err, dbg_exp_err, dbg_after;
    logic        out_chk;
    logic [55:0] exp_ssegs;
    logic        exp_irq;
    logic [31:0] exp_disp;
    logic        model_irq;

    // stimulus table
    logic        ent_dbg  [MAX_ENTRIES];
    logic        ent_we   [MAX_ENTRIES];
    logic [29:0] ent_addr [MAX_ENTRIES];
    logic [31:0] ent_data [MAX_ENTRIES];
    logic [3:0]  ent_sel  [MAX_ENTRIES];
    logic [1:0]  ent_kind [MAX_ENTRIES];
    logic [31:0] ent_exp  [MAX_ENTRIES];
    logic        ent_err  [MAX_ENTRIES];
    logic        ent_pair [MAX_ENTRIES];
    logic [31:0] rnd [4];
    logic [31:0] lcg_state;
    int          n_entries = 0;
    int          cycles = 0;
    int          value_errs, proto_errs;

    wb_soc #(.RAM_ADDR_W(10)) i_wb_soc (
        .i_clk(clk), .i_rst(rst),
        .i_cpu_cyc(cpu_cyc), .i_cpu_stb(cpu_stb), .i_cpu_we(cpu_we),
        .i_cpu_addr(cpu_addr), .i_cpu_data(cpu_data), .i_cpu_sel(cpu_sel),
        .o_cpu_ack(cpu_ack), .o_cpu_stall(cpu_stall), .o_cpu_err(cpu_err),
        .o_cpu_data(cpu_rdata),
        .i_dbg_cyc(dbg_cyc), .i_dbg_stb(dbg_stb), .i_dbg_we(dbg_we),
        .i_dbg_addr(dbg_addr), .i_dbg_data(dbg_data), .i_dbg_sel(dbg_sel),
        .o_dbg_ack(dbg_ack), .o_dbg_stall(dbg_stall), .o_dbg_err(dbg_err),
        .o_dbg_data(dbg_rdata),
        .o_ssegs(ssegs), .o_irq(irq)
    );

    wb_soc_checker u_checker (
        .i_clk(clk), .i_rst(rst),
        .i_cpu_cyc(cpu_cyc), .i_cpu_stb(cpu_stb), .i_cpu_stall(cpu_stall),
        .i_cpu_ack(cpu_ack), .i_cpu_err(cpu_err), .i_cpu_data(cpu_rdata),
        .i_cpu_kind(cpu_kind), .i_cpu_exp(cpu_exp), .i_cpu_exp_err(cpu_exp_err),
        .i_dbg_cyc(dbg_cyc), .i_dbg_stb(dbg_stb), .i_dbg_stall(dbg_stall),
        .i_dbg_ack(dbg_ack), .i_dbg_err(dbg_err), .i_dbg_data(dbg_rdata),
        .i_dbg_kind(dbg_kind), .i_dbg_exp(dbg_exp), .i_dbg_exp_err(dbg_exp_err),
        .i_dbg_after(dbg_after),
        .i_out_chk(out_chk), .i_exp_ssegs(exp_ssegs), .i_exp_irq(exp_irq),
        .i_ssegs(ssegs), .i_irq(irq),
        .o_value_errs(value_errs), .o_proto_errs(proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit grows with the table
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20 * n_entries + 50) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // hex digit to segments a..g, active high
    function automatic logic [6:0] seg_of(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic logic [55:0] segs_of(input logic [31:0] w);
        logic [55:0] s;
        for (int d = 0; d < 8; d++) begin
            s[d*7 +: 7] = seg_of(w[d*4 +: 4]);
        end
        return s;
    endfunction

    function automatic logic port_stall(input logic dbg);
        return dbg ? dbg_stall : cpu_stall;
    endfunction

    function automatic logic port_resp(input logic dbg);
        return dbg ? (dbg_ack | dbg_err) : (cpu_ack | cpu_err);
    endfunction

    task automatic add_entry(input logic dbg, input logic we, input logic [29:0] addr,
                             input logic [31:0] data, input logic [3:0] sel,
                             input logic [1:0] kind, input logic [31:0] exp,
                             input logic err, input logic pair);
        ent_dbg[n_entries]  = dbg;
        ent_we[n_entries]   = we;
        ent_addr[n_entries] = addr;
        ent_data[n_entries] = data;
        ent_sel[n_entries]  = sel;
        ent_kind[n_entries] = kind;
        ent_exp[n_entries]  = exp;
        ent_err[n_entries]  = err;
        ent_pair[n_entries] = pair;
        n_entries++;
    endtask

    task automatic build_table();
        lcg_state = 32'd60729;
        // ram: random words, then read back from both masters
        for (int k = 0; k < 4; k++) begin
            lcg_state = lcg_step(lcg_state);
            rnd[k] = lcg_state;
            add_entry(CPU, 1'b1, RAM_ADDRS[k], rnd[k], 4'hF, K_NONE, 32'h0, 1'b0, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            add_entry(k[0], 1'b0, RAM_ADDRS[k], 32'h0, 4'hF, K_EXACT, rnd[k], 1'b0, 1'b0);
        end
        // byte lane 2 only
        add_entry(DBG, 1'b1, 30'h020, 32'h1122_3344, 4'hF, K_NONE, 32'h0, 1'b0, 1'b0);
        add_entry(DBG, 1'b1, 30'h020, 32'hAABB_CCDD, 4'h4, K_NONE, 32'h0, 1'b0, 1'b0);
        add_entry(DBG, 1'b0, 30'h020, 32'h0, 4'hF, K_EXACT, 32'h11BB_3344, 1'b0, 1'b0);
        // status block at page 1
        add_entry(CPU, 1'b0, 30'h0020_0000, 32'h0, 4'hF, K_EXACT, 32'h2019_1028, 1'b0, 1'b0);
        add_entry(CPU, 1'b1, 30'h0020_0001, 32'hCAFE_F00D, 4'hF, K_NONE, 32'h0, 1'b0, 1'b0);
        add_entry(CPU, 1'b0, 30'h0020_0001, 32'h0, 4'hF, K_EXACT, 32'hCAFE_F00D, 1'b0, 1'b0);
        add_entry(CPU, 1'b1, 30'h0020_0004, 32'h1, 4'hF, K_NONE, 32'h0, 1'b0, 1'b0);
        add_entry(CPU, 1'b0, 30'h0020_0004, 32'h0, 4'hF, K_EXACT, 32'h1, 1'b0, 1'b0);
        add_entry(CPU, 1'b1, 30'h0020_0004, 32'h0, 4'hF, K_NONE, 32'h0, 1'b0, 1'b0);
        add_entry(CPU, 1'b0, 30'h0020_0004, 32'h0, 4'hF, K_EXACT, 32'h0, 1'b0, 1'b0);
        add_entry(CPU, 1'b0, 30'h0020_0003, 32'h0, 4'hF, K_CAPT, 32'h0, 1'b0, 1'b0);
        add_entry(CPU, 1'b0, 30'h0020_0003, 32'h0, 4'hF, K_MORE, 32'h0, 1'b0, 1'b0);
        // page 3 is unmapped, error register holds the byte address
        add_entry(DBG, 1'b0, 30'h0060_0123, 32'h0, 4'hF, K_NONE, 32'h0, 1'b1, 1'b0);
        add_entry(CPU, 1'b0, 30'h0020_0002, 32'h0, 4'hF, K_EXACT, 32'h0180_048C, 1'b0, 1'b0);
        // display
        add_entry(CPU, 1'b1, 30'h0040_0000, 32'h0123_4ABC, 4'hF, K_NONE, 32'h0, 1'b0, 1'b0);
        add_entry(CPU, 1'b0, 30'h0040_0000, 32'h0, 4'hF, K_EXACT, 32'h0123_4ABC, 1'b0, 1'b0);
        // both masters at once, cpu wins
        add_entry(CPU, 1'b0, RAM_ADDRS[0], 32'h0, 4'hF, K_EXACT, rnd[0], 1'b0, 1'b1);
        add_entry(DBG, 1'b0, RAM_ADDRS[1], 32'h0, 4'hF, K_EXACT, rnd[1], 1'b0, 1'b0);
    endtask

    task automatic run_entry(input int idx);
        logic dbg;
        logic after;
        dbg   = ent_dbg[idx];
        after = (idx > 0) && ent_pair[idx-1] && dbg;
        @(posedge clk);
        if (dbg) begin
            dbg_cyc     <= 1'b1;
            dbg_stb     <= 1'b1;
            dbg_we      <= ent_we[idx];
            dbg_addr    <= ent_addr[idx];
            dbg_data    <= ent_data[idx];
            dbg_sel     <= ent_sel[idx];
            dbg_kind    <= ent_kind[idx];
            dbg_exp     <= ent_exp[idx];
            dbg_exp_err <= ent_err[idx];
            dbg_after   <= after;
        end else begin
            cpu_cyc     <= 1'b1;
            cpu_stb     <= 1'b1;
            cpu_we      <= ent_we[idx];
            cpu_addr    <= ent_addr[idx];
            cpu_data    <= ent_data[idx];
            cpu_sel     <= ent_sel[idx];
            cpu_kind    <= ent_kind[idx];
            cpu_exp     <= ent_exp[idx];
            cpu_exp_err <= ent_err[idx];
        end
        // stb held until the arbiter lets it through
        @(negedge clk);
        while (port_stall(dbg)) @(negedge clk);
        @(posedge clk);
        if (dbg) begin
            dbg_stb <= 1'b0;
        end else begin
            cpu_stb <= 1'b0;
        end
        @(negedge clk);
        while (!port_resp(dbg)) @(negedge clk);
        @(posedge clk);
        if (dbg) begin
            dbg_cyc <= 1'b0;
        end else begin
            cpu_cyc <= 1'b0;
        end
    endtask

    task automatic update_model(input int idx);
        if (ent_we[idx] && !ent_err[idx]) begin
            if (ent_addr[idx] == 30'h0040_0000) begin
                exp_disp = ent_data[idx];
            end
            if (ent_addr[idx] == 30'h0020_0004) begin
                model_irq = ent_data[idx][0];
            end
        end
    endtask

    task automatic check_outputs();
        @(posedge clk);
        exp_ssegs <= segs_of(exp_disp);
        exp_irq   <= model_irq;
        out_chk   <= 1'b1;
        @(posedge clk);
        out_chk <= 1'b0;
    endtask

    initial begin
        int i;
        rst = 1'b1;
        {cpu_cyc, cpu_stb, cpu_we, cpu_addr, cpu_data, cpu_sel} = '0;
        {dbg_cyc, dbg_stb, dbg_we, dbg_addr, dbg_data, dbg_sel} = '0;
        {cpu_kind, cpu_exp, cpu_exp_err} = '0;
        {dbg_kind, dbg_exp, dbg_exp_err, dbg_after} = '0;
        {out_chk, exp_ssegs, exp_irq} = '0;
        exp_disp  = 32'h0;
        model_irq = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_outputs();
        i = 0;
        while (i < n_entries) begin
            if (ent_pair[i]) begin
                fork
                    run_entry(i);
                    run_entry(i + 1);
                join
                update_model(i);
                update_model(i + 1);
                i += 2;
            end else begin
                run_entry(i);
                update_model(i);
                i++;
            end
            check_outputs();
        end
        @(negedge clk);
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/wb_soc_checker.sv
`default_nettype none

module wb_soc_checker (
    input  logic        i_clk,
    input  logic        i_rst,
    // cpu port as seen at the DUT, plus what the current request should return
    input  logic        i_cpu_cyc,
    input  logic        i_cpu_stb,
    input  logic        i_cpu_stall,
    input  logic        i_cpu_ack,
    input  logic        i_cpu_err,
    input  logic [31:0] i_cpu_data,
    input  logic [1:0]  i_cpu_kind,
    input  logic [31:0] i_cpu_exp,
    input  logic        i_cpu_exp_err,
    // debug port
    input  logic        i_dbg_cyc,
    input  logic        i_dbg_stb,
    input  logic        i_dbg_stall,
    input  logic        i_dbg_ack,
    input  logic        i_dbg_err,
    input  logic [31:0] i_dbg_data,
    input  logic [1:0]  i_dbg_kind,
    input  logic [31:0] i_dbg_exp,
    input  logic        i_dbg_exp_err,
    input  logic        i_dbg_after,
    // peripheral outputs
    input  logic        i_out_chk,
    input  logic [55:0] i_exp_ssegs,
    input  logic        i_exp_irq,
    input  logic [55:0] i_ssegs,
    input  logic        i_irq,
    output int          o_value_errs,
    output int          o_proto_errs
);

    // data check kinds, same coding as the testbench
    localparam logic [1:0] K_NONE  = 2'd0;
    localparam logic [1:0] K_EXACT = 2'd1;
    localparam logic [1:0] K_CAPT  = 2'd2;
    localparam logic [1:0] K_MORE  = 2'd3;
    localparam int         RESP_LIMIT = 6;

    // entry layout {after cpu, err, kind, data}
    logic [35:0] cpu_q [$];
    logic [35:0] dbg_q [$];
    logic [35:0] ent;
    logic [31:0] captured;
    int          cpu_age;
    int          dbg_age;
    int          value_errs = 0;
    int          proto_errs = 0;

    assign o_value_errs = value_errs;
    assign o_proto_errs = proto_errs;

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
        $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        value_errs++;
    endtask

    task automatic judge(input string port, input logic [35:0] e, input logic ack,
                         input logic err, input logic [31:0] data, input logic other_cyc);
        if (ack && err) begin
            $display("at %0t: %s port saw ack and err together", $time, port);
            proto_errs++;
        end
        if (err != e[34]) begin
            report_value($sformatf("o_%s_err", port), {63'h0, e[34]}, {63'h0, err});
        end
        if (e[35] && other_cyc) begin
            $display("at %0t: debug answered while the cpu still held the bus", $time);
            proto_errs++;
        end
        if (ack && !err) begin
            if (e[33:32] == K_EXACT) begin
                if (data != e[31:0]) begin
                    report_value($sformatf("o_%s_data", port), {32'h0, e[31:0]},
                                 {32'h0, data});
                end
            end else if (e[33:32] == K_CAPT) begin
                captured = data;
            end else if (e[33:32] == K_MORE && !(data > captured)) begin
                $display("CHECK FAILED at %0t: o_%s_data expected above %0h got %0h",
                         $time, port, captured, data);
                value_errs++;
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            cpu_q.delete();
            dbg_q.delete();
            cpu_age = 0;
            dbg_age = 0;
        end else begin
            // requests accepted on this edge
            if (i_cpu_cyc && i_cpu_stb && !i_cpu_stall) begin
                cpu_q.push_back({1'b0, i_cpu_exp_err, i_cpu_kind, i_cpu_exp});
            end
            if (i_dbg_cyc && i_dbg_stb && !i_dbg_stall) begin
                dbg_q.push_back({i_dbg_after, i_dbg_exp_err, i_dbg_kind, i_dbg_exp});
            end

            if (i_cpu_ack || i_cpu_err) begin
                if (cpu_q.size() == 0) begin
                    $display("at %0t: cpu port answered with nothing outstanding", $time);
                    proto_errs++;
                end else begin
                    ent = cpu_q.pop_front();
                    judge("cpu", ent, i_cpu_ack, i_cpu_err, i_cpu_data, 1'b0);
                end
                cpu_age = 0;
            end else if (cpu_q.size() != 0) begin
                cpu_age++;
                if (cpu_age > RESP_LIMIT) begin
                    $display("at %0t: cpu request never got a response", $time);
                    proto_errs++;
                    ent = cpu_q.pop_front();
                    cpu_age = 0;
                end
            end

            if (i_dbg_ack || i_dbg_err) begin
                if (dbg_q.size() == 0) begin
                    $display("at %0t: debug port answered with nothing outstanding", $time);
                    proto_errs++;
                end else begin
                    ent = dbg_q.pop_front();
                    judge("dbg", ent, i_dbg_ack, i_dbg_err, i_dbg_data, i_cpu_cyc);
                end
                dbg_age = 0;
            end else if (dbg_q.size() != 0) begin
                dbg_age++;
                if (dbg_age > RESP_LIMIT) begin
                    $display("at %0t: debug request never got a response", $time);
                    proto_errs++;
                    ent = dbg_q.pop_front();
                    dbg_age = 0;
                end
            end

            // with both masters in a cycle only the non-owner is stalled
            if (i_cpu_cyc && i_dbg_cyc && (i_cpu_stall == i_dbg_stall)) begin
                $display("at %0t: stall not given to exactly one waiting master", $time);
                proto_errs++;
            end

            if (i_out_chk) begin
                if (i_ssegs != i_exp_ssegs) begin
                    report_value("o_ssegs", {8'h0, i_exp_ssegs}, {8'h0, i_ssegs});
                end
                if (i_irq != i_exp_irq) begin
                    report_value("o_irq", {63'h0, i_exp_irq}, {63'h0, i_irq});
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/wb_soc.sv
`default_nettype none

module wb_soc #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    // cpu master, higher priority
    input  logic                    i_cpu_cyc,
    input  logic                    i_cpu_stb,
    input  logic                    i_cpu_we,
    input  wb_soc_pkg::wb_addr_t    i_cpu_addr,
    input  wb_soc_pkg::wb_data_t    i_cpu_data,
    input  wb_soc_pkg::wb_sel_t     i_cpu_sel,
    output logic                    o_cpu_ack,
    output logic                    o_cpu_stall,
    output logic                    o_cpu_err,
    output wb_soc_pkg::wb_data_t    o_cpu_data,
    // debug master
    input  logic                    i_dbg_cyc,
    input  logic                    i_dbg_stb,
    input  logic                    i_dbg_we,
    input  wb_soc_pkg::wb_addr_t    i_dbg_addr,
    input  wb_soc_pkg::wb_data_t    i_dbg_data,
    input  wb_soc_pkg::wb_sel_t     i_dbg_sel,
    output logic                    o_dbg_ack,
    output logic                    o_dbg_stall,
    output logic                    o_dbg_err,
    output wb_soc_pkg::wb_data_t    o_dbg_data,
    // peripherals
    output wb_soc_pkg::seg_digits_t o_ssegs,
    output logic                    o_irq
);

    wb_bus_if cpu_bus ();
    wb_bus_if dbg_bus ();
    wb_bus_if main_bus ();
    wb_bus_if ram_bus ();
    wb_bus_if status_bus ();
    wb_bus_if sseg_bus ();

    wb_soc_pkg::wb_addr_t err_addr;
    logic                 err_stb;

    assign cpu_bus.cyc  = i_cpu_cyc;
    assign cpu_bus.stb  = i_cpu_stb;
    assign cpu_bus.we   = i_cpu_we;
    assign cpu_bus.addr = i_cpu_addr;
    assign cpu_bus.data = i_cpu_data;
    assign cpu_bus.sel  = i_cpu_sel;
    assign o_cpu_ack    = cpu_bus.ack;
    assign o_cpu_stall  = cpu_bus.stall;
    assign o_cpu_err    = cpu_bus.err;
    assign o_cpu_data   = cpu_bus.rdata;

    assign dbg_bus.cyc  = i_dbg_cyc;
    assign dbg_bus.stb  = i_dbg_stb;
    assign dbg_bus.we   = i_dbg_we;
    assign dbg_bus.addr = i_dbg_addr;
    assign dbg_bus.data = i_dbg_data;
    assign dbg_bus.sel  = i_dbg_sel;
    assign o_dbg_ack    = dbg_bus.ack;
    assign o_dbg_stall  = dbg_bus.stall;
    assign o_dbg_err    = dbg_bus.err;
    assign o_dbg_data   = dbg_bus.rdata;

    wb_pri_arbiter u_arbiter (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .a     (cpu_bus),
        .b     (dbg_bus),
        .m     (main_bus)
    );

    wb_bus_decoder u_decoder (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .m          (main_bus),
        .ram_s      (ram_bus),
        .status_s   (status_bus),
        .sseg_s     (sseg_bus),
        .o_err_addr (err_addr),
        .o_err_stb  (err_stb)
    );

    wb_block_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .s     (ram_bus)
    );

    wb_status_regs u_status (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .s          (status_bus),
        .i_err_addr (err_addr),
        .i_err_stb  (err_stb),
        .o_irq      (o_irq)
    );

    wb_sevenseg u_sseg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .s       (sseg_bus),
        .o_ssegs (o_ssegs)
    );

endmodule

`default_nettype wire

//--- source/wb_sevenseg.sv
`default_nettype none

module wb_sevenseg (
    input  logic                    i_clk,
    input  logic                    i_rst,
    wb_bus_if.slave                 s,
    output wb_soc_pkg::seg_digits_t o_ssegs
);
    import wb_soc_pkg::*;

    wb_data_t disp_q;
    logic     ack_q;
    wb_data_t rdata_q;

    // segments a..g on bits 0..6, active high
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'h3F;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5B;
            4'h3:    return 7'h4F;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6D;
            4'h6:    return 7'h7D;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7F;
            4'h9:    return 7'h6F;
            4'hA:    return 7'h77;
            4'hB:    return 7'h7C;
            4'hC:    return 7'h39;
            4'hD:    return 7'h5E;
            4'hE:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q  <= 1'b0;
            disp_q <= '0;
        end else begin
            ack_q <= s.cyc & s.stb;
            // whole word, sel ignored
            if (s.stb && s.we) begin
                disp_q <= s.data;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        rdata_q <= disp_q;
    end

    always_comb begin
        for (int d = 0; d < 8; d++) begin
            o_ssegs[d*7 +: 7] = hex_to_seg(disp_q[d*4 +: 4]);
        end
    end

    assign s.ack   = ack_q;
    assign s.rdata = rdata_q;
    assign s.stall = 1'b0;
    assign s.err   = 1'b0;

endmodule

`default_nettype wire

//--- source/wb_block_ram.sv
`default_nettype none

module wb_block_ram #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic    i_clk,
    input  logic    i_rst,
    wb_bus_if.slave s
);
    import wb_soc_pkg::*;

    wb_data_t              mem [2**RAM_ADDR_W];
    logic [RAM_ADDR_W-1:0] idx;
    logic                  ack_q;
    wb_data_t              rdata_q;

    // low word address bits only, so the page aliases
    assign idx = s.addr[RAM_ADDR_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= s.cyc & s.stb;
        end
    end

    always_ff @(posedge i_clk) begin
        if (s.stb && s.we) begin
            for (int lane = 0; lane < WB_SEL_W; lane++) begin
                if (s.sel[lane]) begin
                    mem[idx][lane*8 +: 8] <= s.data[lane*8 +: 8];
                end
            end
        end
        rdata_q <= mem[idx];
    end

    assign s.ack   = ack_q;
    assign s.rdata = rdata_q;
    assign s.stall = 1'b0;
    assign s.err   = 1'b0;

endmodule

`default_nettype wire

//--- source/wb_status_regs.sv
`default_nettype none

module wb_status_regs (
    input  logic                 i_clk,
    input  logic                 i_rst,
    wb_bus_if.slave              s,
    input  wb_soc_pkg::wb_addr_t i_err_addr,
    input  logic                 i_err_stb,
    output logic                 o_irq
);
    import wb_soc_pkg::*;

    wb_data_t scratch;
    wb_addr_t bus_err_addr;
    wb_data_t power_cnt;
    logic     irq_q;
    logic     ack_q;
    wb_data_t rdata_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q        <= 1'b0;
            irq_q        <= 1'b0;
            power_cnt    <= '0;
            bus_err_addr <= '0;
        end else begin
            ack_q     <= s.cyc & s.stb;
            // wraps around
            power_cnt <= power_cnt + 1'b1;
            if (i_err_stb) begin
                bus_err_addr <= i_err_addr;
            end
            if (s.stb && s.we && (s.addr[3:0] == STATUS_IRQ)) begin
                irq_q <= s.data[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (s.stb && s.we && (s.addr[3:0] == STATUS_SCRATCH)) begin
            scratch <= s.data;
        end
        case (s.addr[3:0])
            STATUS_ID:      rdata_q <= SOC_ID;
            STATUS_SCRATCH: rdata_q <= scratch;
            // byte address of the failed request
            STATUS_BUS_ERR: rdata_q <= {bus_err_addr, 2'b00};
            STATUS_POWER:   rdata_q <= power_cnt;
            STATUS_IRQ:     rdata_q <= {31'h0, irq_q};
            default:        rdata_q <= '0;
        endcase
    end

    assign s.ack   = ack_q;
    assign s.rdata = rdata_q;
    assign s.stall = 1'b0;
    assign s.err   = 1'b0;
    assign o_irq   = irq_q;

endmodule

`default_nettype wire

//--- source/wb_bus_decoder.sv
`default_nettype none

module wb_bus_decoder (
    input  logic                i_clk,
    input  logic                i_rst,
    wb_bus_if.slave             m,
    wb_bus_if.master            ram_s,
    wb_bus_if.master            status_s,
    wb_bus_if.master            sseg_s,
    output wb_soc_pkg::wb_addr_t o_err_addr,
    output logic                o_err_stb
);
    import wb_soc_pkg::*;

    logic     ram_sel;
    logic     status_sel;
    logic     sseg_sel;
    logic     none_sel;
    logic     err_pend;
    wb_addr_t err_addr_q;
    logic     ack_q;
    logic     err_q;
    wb_data_t rdata_q;

    assign ram_sel    = (m.addr[29:21] == PAGE_RAM);
    assign status_sel = (m.addr[29:21] == PAGE_STATUS);
    assign sseg_sel   = (m.addr == SSEG_WORD_ADDR);
    assign none_sel   = !ram_sel && !status_sel && !sseg_sel;

    // request fan-out, only stb is qualified
    assign ram_s.cyc  = m.cyc;
    assign ram_s.stb  = m.stb & ram_sel;
    assign ram_s.we   = m.we;
    assign ram_s.addr = m.addr;
    assign ram_s.data = m.data;
    assign ram_s.sel  = m.sel;

    assign status_s.cyc  = m.cyc;
    assign status_s.stb  = m.stb & status_sel;
    assign status_s.we   = m.we;
    assign status_s.addr = m.addr;
    assign status_s.data = m.data;
    assign status_s.sel  = m.sel;

    assign sseg_s.cyc  = m.cyc;
    assign sseg_s.stb  = m.stb & sseg_sel;
    assign sseg_s.we   = m.we;
    assign sseg_s.addr = m.addr;
    assign sseg_s.data = m.data;
    assign sseg_s.sel  = m.sel;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q    <= 1'b0;
            err_pend <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            ack_q    <= ram_s.ack | status_s.ack | sseg_s.ack;
            err_pend <= m.stb & none_sel;
            err_q    <= err_pend;
        end
    end

    // read data mux, registered once more on the way back
    always_ff @(posedge i_clk) begin
        if (m.stb && none_sel) begin
            err_addr_q <= m.addr;
        end
        if (ram_s.ack) begin
            rdata_q <= ram_s.rdata;
        end else if (status_s.ack) begin
            rdata_q <= status_s.rdata;
        end else if (sseg_s.ack) begin
            rdata_q <= sseg_s.rdata;
        end else begin
            rdata_q <= '0;
        end
    end

    assign m.ack   = ack_q;
    assign m.err   = err_q;
    assign m.rdata = rdata_q;
    assign m.stall = 1'b0;

    // error address lines up with the first stage of the err pipe
    assign o_err_addr = err_addr_q;
    assign o_err_stb  = err_pend;

    a_sel_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        m.stb |-> $onehot0({ram_sel, status_sel, sseg_sel}));
    // every accepted request answered exactly two edges later
    a_resp_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        (m.stb && !m.stall) |-> ##2 (m.ack ^ m.err));

endmodule

`default_nettype wire

//--- source/wb_pri_arbiter.sv
`default_nettype none

module wb_pri_arbiter (
    input  logic     i_clk,
    input  logic     i_rst,
    wb_bus_if.slave  a,
    wb_bus_if.slave  b,
    wb_bus_if.master m
);
    import wb_soc_pkg::*;

    arb_owner_t owner;
    logic       own_a;
    logic       owner_cyc;

    assign own_a     = (owner == OWNER_CPU);
    assign owner_cyc = own_a ? a.cyc : b.cyc;

    // ownership only moves once the current owner has left its cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner <= OWNER_CPU;
        end else if (!owner_cyc) begin
            if (a.cyc) begin
                owner <= OWNER_CPU;
            end else if (b.cyc) begin
                owner <= OWNER_DBG;
            end
        end
    end

    // request path follows the owner
    assign m.cyc  = own_a ? a.cyc  : b.cyc;
    assign m.stb  = own_a ? a.stb  : b.stb;
    assign m.we   = own_a ? a.we   : b.we;
    assign m.addr = own_a ? a.addr : b.addr;
    assign m.data = own_a ? a.data : b.data;
    assign m.sel  = own_a ? a.sel  : b.sel;

    // responses only to the owner, the other one waits on stall
    assign a.ack   = own_a & m.ack;
    assign a.err   = own_a & m.err;
    assign a.stall = own_a ? m.stall : 1'b1;
    assign a.rdata = m.rdata;

    assign b.ack   = !own_a & m.ack;
    assign b.err   = !own_a & m.err;
    assign b.stall = own_a ? 1'b1 : m.stall;
    assign b.rdata = m.rdata;

    // a response belongs to whoever owned the bus when the request went out
    a_ack_issuer_a: assert property (@(posedge i_clk) disable iff (i_rst)
        a.ack |-> $past(own_a, 2));
    a_ack_issuer_b: assert property (@(posedge i_clk) disable iff (i_rst)
        b.ack |-> !$past(own_a, 2));

endmodule

`default_nettype wire

//--- source/wb_bus_if.sv
`default_nettype none

interface wb_bus_if;
    import wb_soc_pkg::*;

    // master to slave
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t addr;
    wb_data_t data;
    wb_sel_t  sel;

    // slave to master
    logic     ack;
    logic     stall;
    logic     err;
    wb_data_t rdata;

    modport master (
        output cyc, stb, we, addr, data, sel,
        input  ack, stall, err, rdata
    );

    modport slave (
        input  cyc, stb, we, addr, data, sel,
        output ack, stall, err, rdata
    );

endinterface

`default_nettype wire

//--- source/wb_soc_pkg.sv
`default_nettype none

package wb_soc_pkg;

    // bus widths
    localparam int WB_ADDR_W = 30;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;

    // eight digits, segments a..g from bit 0, digit 0 lowest
    typedef logic [55:0] seg_digits_t;

    // address map, page is word address bits 29:21
    localparam logic [8:0]           PAGE_RAM       = 9'h000;
    localparam logic [8:0]           PAGE_STATUS    = 9'h001;
    localparam logic [WB_ADDR_W-1:0] SSEG_WORD_ADDR = 30'h0040_0000;

    localparam logic [WB_DATA_W-1:0] SOC_ID = 32'h2019_1028;

    // status block register offsets
    localparam logic [3:0] STATUS_ID      = 4'h0;
    localparam logic [3:0] STATUS_SCRATCH = 4'h1;
    localparam logic [3:0] STATUS_BUS_ERR = 4'h2;
    localparam logic [3:0] STATUS_POWER   = 4'h3;
    localparam logic [3:0] STATUS_IRQ     = 4'h4;

    typedef enum logic {
        OWNER_CPU = 1'b0,
        OWNER_DBG = 1'b1
    } arb_owner_t;

endpackage

`default_nettype wire
